/* design/ooo_cfg.svh */
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// operand and result width, rv32 only
`define XLEN 32

// rob entry tag
`define ROB_TAG_WIDTH 5

// alu opcode field
`define ALU_OP_WIDTH 6

`endif

/* design/ooo_pkg.sv */
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

  // integer alu operations, rv32i plus zba/zbb/zicond
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    ALU_ADD       = 6'd0,
    ALU_SUB       = 6'd1,
    ALU_SH1ADD    = 6'd2,
    ALU_SH2ADD    = 6'd3,
    ALU_SH3ADD    = 6'd4,
    ALU_EQ        = 6'd5,
    ALU_NE        = 6'd6,
    ALU_LT        = 6'd7,
    ALU_LTU       = 6'd8,
    ALU_GE        = 6'd9,
    ALU_GEU       = 6'd10,
    ALU_MIN       = 6'd11,
    ALU_MINU      = 6'd12,
    ALU_MAX       = 6'd13,
    ALU_MAXU      = 6'd14,
    ALU_SLL       = 6'd15,
    ALU_SRL       = 6'd16,
    ALU_SRA       = 6'd17,
    ALU_ROL       = 6'd18,
    ALU_ROR       = 6'd19,
    ALU_CLZ       = 6'd20,
    ALU_CTZ       = 6'd21,
    ALU_CPOP      = 6'd22,
    ALU_AND       = 6'd23,
    ALU_OR        = 6'd24,
    ALU_XOR       = 6'd25,
    ALU_ANDN      = 6'd26,
    ALU_ORN       = 6'd27,
    ALU_XNOR      = 6'd28,
    ALU_SEXTB     = 6'd29,
    ALU_SEXTH     = 6'd30,
    ALU_ZEXTH     = 6'd31,
    ALU_ORCB      = 6'd32,
    ALU_REV8      = 6'd33,
    ALU_CZERO_EQZ = 6'd34,
    ALU_CZERO_NEZ = 6'd35
  } alu_op_t;

endpackage

`default_nettype wire

/* design/cpop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module cpop (
  input  logic [`XLEN-1:0] data_in,
  output logic [`XLEN-1:0] data_out
);

  // adder tree levels, each one bit wider than the last
  logic [1:0] sum2  [16];
  logic [2:0] sum4  [8];
  logic [3:0] sum8  [4];
  logic [4:0] sum16 [2];
  logic [5:0] sum32;

  always_comb begin
    for (int i = 0; i < 16; i++) begin
      sum2[i] = {1'b0, data_in[2*i]} + {1'b0, data_in[2*i+1]};
    end
    for (int i = 0; i < 8; i++) begin
      sum4[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
    end
    for (int i = 0; i < 4; i++) begin
      sum8[i] = {1'b0, sum4[2*i]} + {1'b0, sum4[2*i+1]};
    end
    for (int i = 0; i < 2; i++) begin
      sum16[i] = {1'b0, sum8[2*i]} + {1'b0, sum8[2*i+1]};
    end
    sum32    = {1'b0, sum16[0]} + {1'b0, sum16[1]};
    data_out = {{(`XLEN-6){1'b0}}, sum32};
  end

endmodule

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module alu
  import ooo_pkg::*;
(
  input  alu_op_t          op,
  input  logic [`XLEN-1:0] operand_a,
  input  logic [`XLEN-1:0] operand_b,
  output logic [`XLEN-1:0] result
);

  function automatic logic [`XLEN-1:0] reverse_bits(input logic [`XLEN-1:0] x);
    logic [`XLEN-1:0] y;
    for (int i = 0; i < `XLEN; i++) begin
      y[i] = x[`XLEN-1-i];
    end
    return y;
  endfunction

  // shared adder, bit 0 carries the +1 for subtraction
  logic [`XLEN:0]   add_a;
  logic [`XLEN:0]   add_b;
  logic [`XLEN+1:0] add_sum;
  logic             diff_nz;

  always_comb begin
    unique case (op)
      ALU_SH1ADD: add_a = {operand_a[`XLEN-2:0], 2'b01};
      ALU_SH2ADD: add_a = {operand_a[`XLEN-3:0], 3'b001};
      ALU_SH3ADD: add_a = {operand_a[`XLEN-4:0], 4'b0001};
      default:    add_a = {operand_a, 1'b1};
    endcase
  end

  always_comb begin
    unique case (op)
      ALU_ADD, ALU_SH1ADD, ALU_SH2ADD, ALU_SH3ADD: add_b = {operand_b, 1'b0};
      // everything else subtracts
      default: add_b = {~operand_b, 1'b1};
    endcase
  end

  assign add_sum = {1'b0, add_a} + {1'b0, add_b};
  assign diff_nz = |add_sum[`XLEN:1];

  // a < b, signed or unsigned from carry and sign bits
  logic             less;
  logic [`XLEN-1:0] minmax_res;

  always_comb begin
    unique case (op)
      ALU_LT, ALU_GE, ALU_MIN, ALU_MAX:
        less = (operand_a[`XLEN-1] & ~operand_b[`XLEN-1]) |
               ((operand_a[`XLEN-1] == operand_b[`XLEN-1]) & add_sum[`XLEN]);
      default:
        less = ~add_sum[`XLEN+1];
    endcase
  end

  always_comb begin
    unique case (op)
      ALU_MAX, ALU_MAXU: minmax_res = less ? operand_b : operand_a;
      default:           minmax_res = less ? operand_a : operand_b;
    endcase
  end

  // single right shifter; left forms go through bit reversal
  logic [4:0]       shamt;
  logic [5:0]       wrap_amt;
  logic [`XLEN-1:0] shift_src;
  logic [`XLEN-1:0] shift_fill;
  logic [`XLEN-1:0] shift_res;
  logic [`XLEN-1:0] cnt_src;
  logic [`XLEN-1:0] cnt_res;

  assign shamt    = operand_b[4:0];
  // 32 when shamt is 0, which empties the fill
  assign wrap_amt = 6'd32 - {1'b0, shamt};

  always_comb begin
    unique case (op)
      ALU_SLL, ALU_ROL, ALU_CLZ: shift_src = reverse_bits(operand_a);
      default:                   shift_src = operand_a;
    endcase
  end

  always_comb begin
    unique case (op)
      ALU_SRA:          shift_fill = {`XLEN{operand_a[`XLEN-1]}} << wrap_amt;
      ALU_ROL, ALU_ROR: shift_fill = shift_src << wrap_amt;
      default:          shift_fill = '0;
    endcase
  end

  assign shift_res = (shift_src >> shamt) | shift_fill;

  // trailing zero mask, all ones for a zero word
  always_comb begin
    unique case (op)
      ALU_CLZ, ALU_CTZ: cnt_src = (shift_src - `XLEN'd1) & ~shift_src;
      default:          cnt_src = operand_a;
    endcase
  end

  cpop u_cpop (
    .data_in  (cnt_src),
    .data_out (cnt_res)
  );

  logic [`XLEN-1:0] logic_res;

  always_comb begin
    unique case (op)
      ALU_OR:   logic_res = operand_a | operand_b;
      ALU_XOR:  logic_res = operand_a ^ operand_b;
      ALU_ANDN: logic_res = operand_a & ~operand_b;
      ALU_ORN:  logic_res = operand_a | ~operand_b;
      ALU_XNOR: logic_res = operand_a ^ ~operand_b;
      default:  logic_res = operand_a & operand_b;
    endcase
  end

  // result select
  always_comb begin
    unique case (op)
      ALU_EQ:  result = {{(`XLEN-1){1'b0}}, ~diff_nz};
      ALU_NE:  result = {{(`XLEN-1){1'b0}}, diff_nz};
      ALU_LT, ALU_LTU: result = {{(`XLEN-1){1'b0}}, less};
      ALU_GE, ALU_GEU: result = {{(`XLEN-1){1'b0}}, ~less};
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU: result = minmax_res;
      ALU_SLL, ALU_ROL: result = reverse_bits(shift_res);
      ALU_SRL, ALU_SRA, ALU_ROR: result = shift_res;
      ALU_CLZ, ALU_CTZ, ALU_CPOP: result = cnt_res;
      ALU_AND, ALU_OR, ALU_XOR, ALU_ANDN, ALU_ORN, ALU_XNOR: result = logic_res;
      ALU_SEXTB: result = {{24{operand_a[7]}}, operand_a[7:0]};
      ALU_SEXTH: result = {{16{operand_a[15]}}, operand_a[15:0]};
      ALU_ZEXTH: result = {16'h0000, operand_a[15:0]};
      ALU_ORCB: begin
        result = {{8{|operand_a[31:24]}}, {8{|operand_a[23:16]}},
                  {8{|operand_a[15:8]}}, {8{|operand_a[7:0]}}};
      end
      ALU_REV8: begin
        result = {operand_a[7:0], operand_a[15:8],
                  operand_a[23:16], operand_a[31:24]};
      end
      ALU_CZERO_EQZ: result = (|operand_b) ? operand_a : '0;
      ALU_CZERO_NEZ: result = (|operand_b) ? '0 : operand_a;
      // add, sub and shNadd
      default: result = add_sum[`XLEN:1];
    endcase
  end

endmodule

`default_nettype wire

/* design/alu_fu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module alu_fu
  import ooo_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      issue_valid,
  input  alu_op_t                   issue_op,
  input  logic [`XLEN-1:0]          issue_a,
  input  logic [`XLEN-1:0]          issue_b,
  input  logic [`ROB_TAG_WIDTH-1:0] issue_tag,
  input  logic                      flush,
  output logic                      result_valid,
  output logic [`ROB_TAG_WIDTH-1:0] result_tag,
  output logic [`XLEN-1:0]          result_data
);

  // issue stage
  logic                      s1_valid;
  alu_op_t                   s1_op;
  logic [`XLEN-1:0]          s1_a;
  logic [`XLEN-1:0]          s1_b;
  logic [`ROB_TAG_WIDTH-1:0] s1_tag;

  logic [`XLEN-1:0]          alu_result;

  // flush kills both stages, including an issue in the same cycle
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      s1_op  <= issue_op;
      s1_a   <= issue_a;
      s1_b   <= issue_b;
      s1_tag <= issue_tag;
    end
  end

  alu u_alu (
    .op        (s1_op),
    .operand_a (s1_a),
    .operand_b (s1_b),
    .result    (alu_result)
  );

  // writeback stage
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result_tag  <= s1_tag;
      result_data <= alu_result;
    end
  end

endmodule

`default_nettype wire

/* test/alu_fu_props.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_fu_props (
  input logic clk,
  input logic reset,
  input logic issue_valid,
  input logic flush,
  input logic result_valid
);

  // pipeline is empty right after reset
  assert property (@(posedge clk) reset |=> !result_valid)
    else $error("result_valid high in the cycle after reset");

  // an issue that escapes flush comes out two edges later
  assert property (@(posedge clk) disable iff (reset)
    (issue_valid && !flush) ##1 !flush |=> result_valid)
    else $error("issued operation did not produce result_valid");

  assert property (@(posedge clk) disable iff (reset)
    result_valid |-> $past(issue_valid, 2))
    else $error("result_valid without a matching issue");

endmodule

bind alu_fu alu_fu_props u_alu_fu_props (
  .clk          (clk),
  .reset        (reset),
  .issue_valid  (issue_valid),
  .flush        (flush),
  .result_valid (result_valid)
);

`default_nettype wire

/* test/tb_alu_fu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_cfg.svh"

module tb_alu_fu
  import ooo_pkg::*;
;

  localparam int NUM_RANDOM = 500;

  logic                      clk;
  logic                      reset;
  logic                      issue_valid;
  alu_op_t                   issue_op;
  logic [`XLEN-1:0]          issue_a;
  logic [`XLEN-1:0]          issue_b;
  logic [`ROB_TAG_WIDTH-1:0] issue_tag;
  logic                      flush;
  logic                      result_valid;
  logic [`ROB_TAG_WIDTH-1:0] result_tag;
  logic [`XLEN-1:0]          result_data;

  // directed rows of op, a, b and expected value
  alu_op_t          tbl_op  [$];
  logic [`XLEN-1:0] tbl_a   [$];
  logic [`XLEN-1:0] tbl_b   [$];
  logic [`XLEN-1:0] tbl_exp [$];

  // in-flight scoreboard
  logic [`XLEN-1:0]          exp_q [$];
  logic [`ROB_TAG_WIDTH-1:0] tag_q [$];
  int                        due_q [$];

  logic [`ROB_TAG_WIDTH-1:0] next_tag = '0;
  int                        cycle = 0;
  int                        seed;

  alu_fu u_alu_fu (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [`XLEN-1:0] got,
                       input logic [`XLEN-1:0] expected);
    if (got !== expected) begin
      $display("ERROR %s got %h expected %h", name, got, expected);
      abort_run("value mismatch");
    end
  endtask

  // expected result straight from the RISC-V definitions
  function automatic logic [`XLEN-1:0] ref_alu(input alu_op_t op, input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    int               n;
    r = '0;
    n = b[4:0];
    case (op)
      ALU_ADD:    r = a + b;
      ALU_SUB:    r = a - b;
      ALU_SH1ADD: r = (a << 1) + b;
      ALU_SH2ADD: r = (a << 2) + b;
      ALU_SH3ADD: r = (a << 3) + b;
      ALU_EQ:     r = (a == b);
      ALU_NE:     r = (a != b);
      ALU_LT:     r = ($signed(a) < $signed(b));
      ALU_LTU:    r = (a < b);
      ALU_GE:     r = ($signed(a) >= $signed(b));
      ALU_GEU:    r = (a >= b);
      ALU_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      ALU_MINU:   r = (a < b) ? a : b;
      ALU_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
      ALU_MAXU:   r = (a < b) ? b : a;
      ALU_SLL:    r = a << n;
      ALU_SRL:    r = a >> n;
      ALU_SRA:    r = $signed(a) >>> n;
      ALU_ROL:    r = (a << n) | (a >> (32 - n));
      ALU_ROR:    r = (a >> n) | (a << (32 - n));
      ALU_CLZ: begin
        for (int i = 31; i >= 0 && !a[i]; i--) r = r + 1;
      end
      ALU_CTZ: begin
        for (int i = 0; i < 32 && !a[i]; i++) r = r + 1;
      end
      ALU_CPOP:   r = $countones(a);
      ALU_AND:    r = a & b;
      ALU_OR:     r = a | b;
      ALU_XOR:    r = a ^ b;
      ALU_ANDN:   r = a & ~b;
      ALU_ORN:    r = a | ~b;
      ALU_XNOR:   r = ~(a ^ b);
      ALU_SEXTB:  r = {{24{a[7]}}, a[7:0]};
      ALU_SEXTH:  r = {{16{a[15]}}, a[15:0]};
      ALU_ZEXTH:  r = {16'h0000, a[15:0]};
      ALU_ORCB: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
      end
      ALU_REV8: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = a[8*(3-i) +: 8];
      end
      ALU_CZERO_EQZ: r = (b == 0) ? '0 : a;
      ALU_CZERO_NEZ: r = (b != 0) ? '0 : a;
      default:    r = 'x;
    endcase
    return r;
  endfunction

  task automatic add_row(input alu_op_t op, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] expected);
    tbl_op.push_back(op);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(expected);
  endtask

  task automatic load_table();
    add_row(ALU_ADD,       32'h7fffffff, 32'h00000001, 32'h80000000);
    add_row(ALU_ADD,       32'hffffffff, 32'h00000001, 32'h00000000);
    add_row(ALU_SUB,       32'h80000000, 32'h00000001, 32'h7fffffff);
    add_row(ALU_SH1ADD,    32'h80000001, 32'h00000001, 32'h00000003);
    add_row(ALU_SH2ADD,    32'h00000003, 32'h00000010, 32'h0000001c);
    add_row(ALU_SH3ADD,    32'hf0000001, 32'hffffffff, 32'h80000007);
    add_row(ALU_EQ,        32'h12345678, 32'h12345678, 32'h00000001);
    add_row(ALU_NE,        32'h12345678, 32'h12345679, 32'h00000001);
    add_row(ALU_LT,        32'hffffffff, 32'h00000001, 32'h00000001);
    add_row(ALU_LTU,       32'hffffffff, 32'h00000001, 32'h00000000);
    add_row(ALU_GE,        32'h80000000, 32'h7fffffff, 32'h00000000);
    add_row(ALU_GEU,       32'h80000000, 32'h7fffffff, 32'h00000001);
    add_row(ALU_MIN,       32'hffffffff, 32'h00000001, 32'hffffffff);
    add_row(ALU_MINU,      32'hffffffff, 32'h00000001, 32'h00000001);
    add_row(ALU_MAX,       32'h80000000, 32'h7fffffff, 32'h7fffffff);
    add_row(ALU_MAXU,      32'h80000000, 32'h7fffffff, 32'h80000000);
    add_row(ALU_SLL,       32'h00000001, 32'h0000001f, 32'h80000000);
    add_row(ALU_SLL,       32'h12345678, 32'h00000020, 32'h12345678);
    add_row(ALU_SRL,       32'h80000000, 32'h0000001f, 32'h00000001);
    add_row(ALU_SRA,       32'h80000000, 32'h0000001f, 32'hffffffff);
    add_row(ALU_ROL,       32'h80000001, 32'h00000001, 32'h00000003);
    add_row(ALU_ROR,       32'h80000001, 32'h00000001, 32'hc0000000);
    add_row(ALU_ROR,       32'h12345678, 32'h00000000, 32'h12345678);
    add_row(ALU_CLZ,       32'h00000000, 32'h00000000, 32'h00000020);
    add_row(ALU_CLZ,       32'h00010000, 32'h00000000, 32'h0000000f);
    add_row(ALU_CTZ,       32'h00000000, 32'h00000000, 32'h00000020);
    add_row(ALU_CTZ,       32'h00010000, 32'h00000000, 32'h00000010);
    add_row(ALU_CPOP,      32'hf0f0000f, 32'h00000000, 32'h0000000c);
    add_row(ALU_AND,       32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
    add_row(ALU_OR,        32'hf0f0f0f0, 32'hff00ff00, 32'hfff0fff0);
    add_row(ALU_XOR,       32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0);
    add_row(ALU_ANDN,      32'hf0f0f0f0, 32'hff00ff00, 32'h00f000f0);
    add_row(ALU_ORN,       32'hf0f0f0f0, 32'hff00ff00, 32'hf0fff0ff);
    add_row(ALU_XNOR,      32'hf0f0f0f0, 32'hff00ff00, 32'hf00ff00f);
    add_row(ALU_SEXTB,     32'h00000080, 32'h00000000, 32'hffffff80);
    add_row(ALU_SEXTH,     32'h12348000, 32'h00000000, 32'hffff8000);
    add_row(ALU_ZEXTH,     32'hffff8000, 32'h00000000, 32'h00008000);
    add_row(ALU_ORCB,      32'h00100001, 32'h00000000, 32'h00ff00ff);
    add_row(ALU_REV8,      32'h12345678, 32'h00000000, 32'h78563412);
    add_row(ALU_CZERO_EQZ, 32'h12345678, 32'h00000000, 32'h00000000);
    add_row(ALU_CZERO_EQZ, 32'h12345678, 32'h00000005, 32'h12345678);
    add_row(ALU_CZERO_NEZ, 32'h12345678, 32'h00000000, 32'h12345678);
  endtask

  // one issue per call; kept ops are expected back two edges later
  task automatic drive_op(input alu_op_t op, input logic [`XLEN-1:0] a,
                          input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] expected,
                          input logic flush_now, input logic keep);
    @(posedge clk);
    #10;
    issue_valid = 1'b1;
    issue_op    = op;
    issue_a     = a;
    issue_b     = b;
    issue_tag   = next_tag;
    flush       = flush_now;
    if (keep) begin
      exp_q.push_back(expected);
      tag_q.push_back(next_tag);
      due_q.push_back(cycle + 2);
    end
    next_tag = next_tag + 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #10;
    issue_valid = 1'b0;
    flush       = 1'b0;
  endtask

  // results are stable at the falling edge
  always @(negedge clk) begin
    if (!reset && result_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("result_valid went high with no operation in flight");
      end else begin
        check("result_valid cycle", cycle, due_q.pop_front());
        check("result_tag", result_tag, tag_q.pop_front());
        check("result_data", result_data, exp_q.pop_front());
      end
    end
  end

  // at most one gap per random op
  initial begin
    #((42 + 2 * NUM_RANDOM + 40) * 100);
    abort_run("timeout, the test did not finish in time");
  end

  initial begin : stimulus
    logic [`XLEN-1:0] rnd_a;
    logic [`XLEN-1:0] rnd_b;
    logic [31:0]      op_idx;
    alu_op_t          rnd_op;
    seed        = 30804;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_op    = ALU_ADD;
    issue_a     = '0;
    issue_b     = '0;
    issue_tag   = '0;
    flush       = 1'b0;
    load_table();
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    repeat (3) idle_cycle();

    for (int i = 0; i < tbl_op.size(); i++) begin
      drive_op(tbl_op[i], tbl_a[i], tbl_b[i], tbl_exp[i], 1'b0, 1'b1);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      op_idx = {$random(seed)} % 36;
      rnd_op = alu_op_t'(op_idx[5:0]);
      rnd_a  = $random(seed);
      rnd_b  = $random(seed);
      drive_op(rnd_op, rnd_a, rnd_b, ref_alu(rnd_op, rnd_a, rnd_b), 1'b0, 1'b1);
      if (($random(seed) & 3) == 0) begin
        idle_cycle();
      end
    end
    repeat (4) idle_cycle();

    // flush edge finds the or in the result register and the add in stage 1
    // the sub is issued in the flush cycle
    drive_op(ALU_OR, 32'h0f, 32'hf0, 32'hff, 1'b0, 1'b1);
    drive_op(ALU_ADD, 32'h1, 32'h2, 32'h3, 1'b0, 1'b0);
    drive_op(ALU_SUB, 32'h5, 32'h1, 32'h4, 1'b1, 1'b0);
    drive_op(ALU_XOR, 32'hff, 32'h0f, 32'hf0, 1'b0, 1'b1);
    drive_op(ALU_REV8, 32'h11223344, 32'h0, 32'h44332211, 1'b0, 1'b1);
    repeat (4) idle_cycle();

    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("some issued operations never produced a result");
    end
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+design
design/ooo_pkg.sv
design/cpop.sv
design/alu.sv
design/alu_fu.sv
test/alu_fu_props.sv
test/tb_alu_fu.sv
